/* hw/dispatch_pkg.sv */
// shared dispatch types; RV64I only, no compressed forms, fence sets ordered i/o/r/w from bit 3
`default_nettype none

package dispatch_pkg;

	// issue queue index equals the enum value, the fence has no queue
	typedef enum logic [3:0] {
		UNIT_ADDER  = 4'd0,
		UNIT_LOGCMP = 4'd1,
		UNIT_SHIFT  = 4'd2,
		UNIT_JAL    = 4'd3,
		UNIT_BRU    = 4'd4,
		UNIT_LU     = 4'd5,
		UNIT_SU     = 4'd6,
		UNIT_CSR    = 4'd7,
		UNIT_FENCE  = 4'd8
	} unit_e;

	localparam int NUM_UNITS = 8;
	localparam int RN_DEPTH = 4;
	localparam int RN_BITS = 2;

	typedef logic [RN_BITS-1:0] rn_slot_t;

	typedef struct packed {
		logic [55:0] unused;
		logic [3:0]  pred;
		logic [3:0]  succ;
	} fence_imm_t;

	// the same immediate word, read as a value or as fence sets
	typedef union packed {
		logic [63:0] value;
		fence_imm_t  fence;
	} imm_u;

	typedef struct packed {
		unit_e       unit;
		logic [3:0]  op;
		logic [63:0] pc;
		imm_u        imm;
		logic [4:0]  rd0;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic        rd0_valid;
	} decoded_t;

	typedef struct packed {
		logic [3:0]  op;
		logic [63:0] pc;
		imm_u        imm;
		logic [4:0]  rd0;
		rn_slot_t    rd0_slot;
		rn_slot_t    rs1_slot;
		rn_slot_t    rs2_slot;
	} issue_info_t;

	typedef struct packed {
		logic [63:0] pc;
		logic [4:0]  rd0;
		rn_slot_t    rd0_slot;
		logic        rd0_valid;
		logic        is_branch;
	} rob_entry_t;

endpackage

`default_nettype wire

/* hw/rename_if.sv */
// operand renaming request and result; source slots are combinational, alloc is taken at the edge
`default_nettype none
`timescale 1ns/1ps

interface rename_if;

	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd0;
	logic       rd0_valid;
	logic       alloc;

	dispatch_pkg::rn_slot_t rs1_slot;
	dispatch_pkg::rn_slot_t rs2_slot;
	dispatch_pkg::rn_slot_t rd0_slot;
	logic                   run_out;

	modport renamer (
		input  rs1, rs2, rd0, rd0_valid, alloc,
		output rs1_slot, rs2_slot, rd0_slot, run_out
	);

	modport dispatcher (
		output rs1, rs2, rd0, rd0_valid, alloc,
		input  rs1_slot, rs2_slot, rd0_slot, run_out
	);

endinterface

`default_nettype wire

/* hw/sync_fifo.sv */
// show-ahead FIFO; a push while full and a pop while empty are ignored, head data is X when empty
`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// oldest entry always on the output
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (!do_push && do_pop) begin
				count <= count - 1'b1;
			end
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) !(push && full))
		else $error("push while full was dropped");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) !(pop && empty))
		else $error("pop while empty was ignored");

endmodule

`default_nettype wire

/* hw/rename.sv */
// RN_DEPTH rename slots per register; x0 never allocated, commit must name a slot in use
`default_nettype none
`timescale 1ns/1ps

module rename (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   commit,
	input  logic [4:0]             commit_rd0,
	input  dispatch_pkg::rn_slot_t commit_slot,
	input  logic                   commit_rd0_valid,
	rename_if.renamer              rn
);

	// x0 entries are never written and stay at their reset value
	logic [dispatch_pkg::RN_DEPTH-1:0] used [32];
	dispatch_pkg::rn_slot_t            active [32];
	dispatch_pkg::rn_slot_t            free_slot;
	logic                              do_release;
	logic                              do_alloc;

	// lowest free slot of the destination
	always_comb begin
		free_slot = '0;
		for (int i = dispatch_pkg::RN_DEPTH - 1; i >= 0; i--) begin
			if (!used[rn.rd0][i]) begin
				free_slot = dispatch_pkg::rn_slot_t'(i);
			end
		end
	end

	assign rn.rs1_slot = active[rn.rs1];
	assign rn.rs2_slot = active[rn.rs2];
	assign rn.rd0_slot = free_slot;
	assign rn.run_out = rn.rd0_valid & (rn.rd0 != 5'd0) & (&used[rn.rd0]);

	assign do_release = commit & commit_rd0_valid & (commit_rd0 != 5'd0);
	assign do_alloc = rn.alloc & (rn.rd0 != 5'd0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < 32; r++) begin
				used[r] <= '0;
				active[r] <= '0;
			end
		end else begin
			if (do_release) begin
				used[commit_rd0][commit_slot] <= 1'b0;
			end
			// new producer becomes the active copy for later readers
			if (do_alloc) begin
				used[rn.rd0][free_slot] <= 1'b1;
				active[rn.rd0] <= free_slot;
			end
		end
	end

	// retired slot was handed out by an earlier dispatch
	a_release_in_use: assert property (@(posedge clk) disable iff (!arst_n)
		do_release |-> used[commit_rd0][commit_slot])
		else $error("commit released a rename slot that is not in use");

endmodule

`default_nettype wire

/* hw/dispatch.sv */
// in-order single dispatch; no flush, fences stall the whole stream until memory ops drain
`default_nettype none
`timescale 1ns/1ps

module dispatch (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  dispatch_pkg::decoded_t               head,
	input  logic                                 ififo_empty,
	output logic                                 ififo_pop,
	input  logic                                 rob_full,
	output logic                                 rob_push,
	output dispatch_pkg::rob_entry_t             rob_entry,
	input  logic [dispatch_pkg::NUM_UNITS-1:0]   issue_full,
	output logic [dispatch_pkg::NUM_UNITS-1:0]   issue_push,
	output dispatch_pkg::issue_info_t            issue_info,
	input  logic                                 su_empty,
	input  logic                                 lu_busy,
	input  logic                                 commit,
	input  logic [4:0]                           commit_rd0,
	input  dispatch_pkg::rn_slot_t               commit_slot,
	input  logic                                 commit_rd0_valid
);

	logic [3:0] unit_code;
	logic       is_fence;
	logic       is_fence_i;
	logic       pred_st;
	logic       pred_ld;
	logic       succ_mem;
	logic       fence_hold;
	logic       unit_ready;
	logic       dispatch_go;

	rename_if rn_bus ();

	rename u_rename (
		.clk              (clk),
		.arst_n           (arst_n),
		.commit           (commit),
		.commit_rd0       (commit_rd0),
		.commit_slot      (commit_slot),
		.commit_rd0_valid (commit_rd0_valid),
		.rn               (rn_bus.renamer)
	);

	assign unit_code = head.unit;
	assign is_fence = (head.unit == dispatch_pkg::UNIT_FENCE);
	// op 1 of the fence class is fence.i
	assign is_fence_i = is_fence & (head.op == 4'd1);

	// o and w order stores, i and r order loads
	assign pred_st = |(head.imm.fence.pred & 4'b0101);
	assign pred_ld = |(head.imm.fence.pred & 4'b1010);
	assign succ_mem = |head.imm.fence.succ;

	always_comb begin
		if (is_fence_i) begin
			fence_hold = ~su_empty | lu_busy;
		end else begin
			fence_hold = succ_mem & ((pred_st & ~su_empty) | (pred_ld & lu_busy));
		end
	end

	assign unit_ready = is_fence ? ~fence_hold : ~issue_full[unit_code[2:0]];
	assign dispatch_go = ~ififo_empty & ~rob_full & ~rn_bus.run_out & unit_ready;

	always_comb begin
		issue_push = '0;
		if (dispatch_go && !is_fence) begin
			issue_push[unit_code[2:0]] = 1'b1;
		end
	end

	assign ififo_pop = dispatch_go;
	assign rob_push = dispatch_go;

	assign rn_bus.rs1 = head.rs1;
	assign rn_bus.rs2 = head.rs2;
	assign rn_bus.rd0 = head.rd0;
	assign rn_bus.rd0_valid = head.rd0_valid;
	assign rn_bus.alloc = dispatch_go & head.rd0_valid & (head.rd0 != 5'd0);

	assign issue_info.op = head.op;
	assign issue_info.pc = head.pc;
	assign issue_info.imm = head.imm;
	assign issue_info.rd0 = head.rd0;
	assign issue_info.rd0_slot = rn_bus.rd0_slot;
	assign issue_info.rs1_slot = rn_bus.rs1_slot;
	assign issue_info.rs2_slot = rn_bus.rs2_slot;

	assign rob_entry.pc = head.pc;
	assign rob_entry.rd0 = head.rd0;
	assign rob_entry.rd0_slot = rn_bus.rd0_slot;
	assign rob_entry.rd0_valid = head.rd0_valid;
	assign rob_entry.is_branch = (head.unit == dispatch_pkg::UNIT_BRU)
		| (head.unit == dispatch_pkg::UNIT_JAL);

	// codes above the fence class would alias onto a queue index
	a_known_unit: assert property (@(posedge clk) disable iff (!arst_n)
		!ififo_empty |-> (!unit_code[3] || unit_code[2:0] == 3'd0))
		else $error("unknown unit class at the instruction FIFO head");

endmodule

`default_nettype wire

/* hw/dispatch_top.sv */
// dispatch stage with instruction and reorder FIFOs; commit is ignored while commit_valid is low
`default_nettype none
`timescale 1ns/1ps

module dispatch_top #(
	parameter int IFIFO_DEPTH = 4,
	parameter int ROB_DEPTH = 8
) (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               decode_push,
	input  dispatch_pkg::decoded_t             decode_info,
	output logic                               decode_full,
	input  logic [dispatch_pkg::NUM_UNITS-1:0] issue_full,
	output logic [dispatch_pkg::NUM_UNITS-1:0] issue_push,
	output dispatch_pkg::issue_info_t          issue_info,
	input  logic                               su_empty,
	input  logic                               lu_busy,
	input  logic                               commit,
	output logic                               commit_valid,
	output logic [63:0]                        commit_pc,
	output logic [4:0]                         commit_rd0,
	output dispatch_pkg::rn_slot_t             commit_slot,
	output logic                               commit_is_branch
);

	dispatch_pkg::decoded_t   head;
	dispatch_pkg::rob_entry_t rob_entry;
	dispatch_pkg::rob_entry_t rob_head;
	logic                     ififo_empty;
	logic                     ififo_pop;
	logic                     rob_push;
	logic                     rob_full;
	logic                     rob_empty;
	logic                     commit_fire;

	sync_fifo #(
		.WIDTH ($bits(dispatch_pkg::decoded_t)),
		.DEPTH (IFIFO_DEPTH)
	) u_ififo (
		.clk      (clk),
		.arst_n   (arst_n),
		.push     (decode_push),
		.data_in  (decode_info),
		.pop      (ififo_pop),
		.data_out (head),
		.full     (decode_full),
		.empty    (ififo_empty)
	);

	dispatch u_dispatch (
		.clk              (clk),
		.arst_n           (arst_n),
		.head             (head),
		.ififo_empty      (ififo_empty),
		.ififo_pop        (ififo_pop),
		.rob_full         (rob_full),
		.rob_push         (rob_push),
		.rob_entry        (rob_entry),
		.issue_full       (issue_full),
		.issue_push       (issue_push),
		.issue_info       (issue_info),
		.su_empty         (su_empty),
		.lu_busy          (lu_busy),
		.commit           (commit_fire),
		.commit_rd0       (rob_head.rd0),
		.commit_slot      (rob_head.rd0_slot),
		.commit_rd0_valid (rob_head.rd0_valid)
	);

	sync_fifo #(
		.WIDTH ($bits(dispatch_pkg::rob_entry_t)),
		.DEPTH (ROB_DEPTH)
	) u_rob (
		.clk      (clk),
		.arst_n   (arst_n),
		.push     (rob_push),
		.data_in  (rob_entry),
		.pop      (commit_fire),
		.data_out (rob_head),
		.full     (rob_full),
		.empty    (rob_empty)
	);

	assign commit_valid = ~rob_empty;
	assign commit_fire = commit & ~rob_empty;
	assign commit_pc = rob_head.pc;
	assign commit_rd0 = rob_head.rd0;
	assign commit_slot = rob_head.rd0_slot;
	assign commit_is_branch = rob_head.is_branch;

endmodule

`default_nettype wire

/* verification/dispatch_tb.sv */
// case-driven testbench; run from the project root, stops at the first mismatch, ROB depth 8 assumed
`default_nettype none
`timescale 1ns/1ps

module dispatch_tb;

	logic                        clk;
	logic                        arst_n;
	logic                        decode_push;
	dispatch_pkg::decoded_t      decode_info;
	logic                        decode_full;
	logic [7:0]                  issue_full;
	logic [7:0]                  issue_push;
	dispatch_pkg::issue_info_t   issue_info;
	logic                        su_empty;
	logic                        lu_busy;
	logic                        commit;
	logic                        commit_valid;
	logic [63:0]                 commit_pc;
	logic [4:0]                  commit_rd0;
	dispatch_pkg::rn_slot_t      commit_slot;
	logic                        commit_is_branch;

	dispatch_pkg::issue_info_t   seen_info [$];
	logic [7:0]                  seen_push [$];
	dispatch_pkg::rob_entry_t    rob_model [$];
	integer                      seed;
	integer                      fd;
	integer                      code;
	string                       line;
	string                       name;
	logic [63:0]                 unit_v;
	logic [63:0]                 op_v;
	logic [63:0]                 pc_v;
	logic [63:0]                 imm_v;
	logic [63:0]                 rd0_v;
	logic [63:0]                 rs1_v;
	logic [63:0]                 rs2_v;
	logic [63:0]                 rdv_v;
	logic [63:0]                 full_v;
	logic [63:0]                 su_v;
	logic [63:0]                 lu_v;
	logic [63:0]                 ncom_v;
	logic [63:0]                 stall_v;
	logic [63:0]                 ers1_v;
	logic [63:0]                 ers2_v;
	logic [63:0]                 erd0_v;

	dispatch_top #(.IFIFO_DEPTH(4), .ROB_DEPTH(8)) dut (
		.clk              (clk),
		.arst_n           (arst_n),
		.decode_push      (decode_push),
		.decode_info      (decode_info),
		.decode_full      (decode_full),
		.issue_full       (issue_full),
		.issue_push       (issue_push),
		.issue_info       (issue_info),
		.su_empty         (su_empty),
		.lu_busy          (lu_busy),
		.commit           (commit),
		.commit_valid     (commit_valid),
		.commit_pc        (commit_pc),
		.commit_rd0       (commit_rd0),
		.commit_slot      (commit_slot),
		.commit_is_branch (commit_is_branch)
	);

	always #50 clk = ~clk;

	// every dispatch is captured mid-cycle, also while a commit is in progress
	always @(negedge clk) begin
		if (arst_n && dut.rob_push) begin
			seen_info.push_back(issue_info);
			seen_push.push_back(issue_push);
		end
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_issue(input string tname, input dispatch_pkg::unit_e unit,
			input dispatch_pkg::issue_info_t exp, input dispatch_pkg::issue_info_t act,
			input logic [7:0] act_push);
		logic [7:0] exp_push;
		exp_push = (unit == dispatch_pkg::UNIT_FENCE) ? 8'h00 : (8'h01 << unit[2:0]);
		if (act_push !== exp_push)
			stop_run($sformatf("ERROR %s issue_push expected %h actual %h",
				tname, exp_push, act_push));
		if (act !== exp)
			stop_run($sformatf("ERROR %s issue_info expected %h actual %h",
				tname, exp, act));
	endtask

	task automatic check_commit(input string tname, input dispatch_pkg::rob_entry_t exp);
		if ({commit_pc, commit_rd0, commit_slot, commit_is_branch}
				!== {exp.pc, exp.rd0, exp.rd0_slot, exp.is_branch})
			stop_run($sformatf("ERROR %s commit expected %h/%h/%h/%b actual %h/%h/%h/%b", tname,
				exp.pc, exp.rd0, exp.rd0_slot, exp.is_branch,
				commit_pc, commit_rd0, commit_slot, commit_is_branch));
	endtask

	task automatic check_level(input string tname, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("ERROR %s level expected %b actual %b", tname, exp, act));
	endtask

	task automatic do_commit(input string tname);
		int i;
		for (i = 0; i < 50 && commit_valid !== 1'b1; i++)
			@(negedge clk);
		if (commit_valid !== 1'b1)
			stop_run($sformatf("timeout in %s waiting for a reorder entry to commit", tname));
		@(posedge clk);
		#1 commit = 1'b1;
		@(negedge clk);
		check_commit(tname, rob_model.pop_front());
		@(posedge clk);
		#1 commit = 1'b0;
	endtask

	task automatic wait_dispatch(input string tname, input dispatch_pkg::unit_e unit,
			input dispatch_pkg::issue_info_t exp, input dispatch_pkg::rob_entry_t entry);
		int i;
		for (i = 0; i < 50 && seen_push.size() == 0; i++)
			@(negedge clk);
		if (seen_push.size() == 0)
			stop_run($sformatf("timeout in %s, the instruction never dispatched", tname));
		check_issue(tname, unit, exp, seen_info.pop_front(), seen_push.pop_front());
		rob_model.push_back(entry);
	endtask

	task automatic run_case();
		dispatch_pkg::decoded_t    d;
		dispatch_pkg::decoded_t    follow;
		dispatch_pkg::issue_info_t exp;
		dispatch_pkg::issue_info_t follow_exp;
		dispatch_pkg::rob_entry_t  entry;
		dispatch_pkg::rob_entry_t  follow_entry;
		dispatch_pkg::unit_e       unit;
		logic                      followed;
		int                        i;
		unit = dispatch_pkg::unit_e'(unit_v[3:0]);
		d.unit = unit;
		d.op = op_v[3:0];
		d.pc = pc_v;
		d.imm.value = imm_v;
		d.rd0 = rd0_v[4:0];
		d.rs1 = rs1_v[4:0];
		d.rs2 = rs2_v[4:0];
		d.rd0_valid = rdv_v[0];
		exp.op = d.op;
		exp.pc = d.pc;
		exp.imm = d.imm;
		exp.rd0 = d.rd0;
		exp.rd0_slot = erd0_v[1:0];
		exp.rs1_slot = ers1_v[1:0];
		exp.rs2_slot = ers2_v[1:0];
		entry.pc = d.pc;
		entry.rd0 = d.rd0;
		entry.rd0_slot = erd0_v[1:0];
		entry.rd0_valid = d.rd0_valid;
		entry.is_branch = (unit == dispatch_pkg::UNIT_BRU) || (unit == dispatch_pkg::UNIT_JAL);
		// only x0 is named, so every slot reads as 0
		follow = '0;
		follow.unit = dispatch_pkg::UNIT_ADDER;
		follow.pc = d.pc + 64'h1000;
		follow_exp = '0;
		follow_exp.pc = follow.pc;
		follow_entry = '0;
		follow_entry.pc = follow.pc;
		followed = stall_v[0] & (full_v[7:0] != 8'h00);
		for (i = 0; i < 50 && decode_full !== 1'b0; i++)
			@(negedge clk);
		if (decode_full !== 1'b0)
			stop_run($sformatf("timeout in %s, instruction FIFO stayed full", name));
		@(posedge clk);
		#1;
		issue_full = full_v[7:0];
		su_empty = su_v[0];
		lu_busy = lu_v[0];
		decode_info = d;
		decode_push = 1'b1;
		@(posedge clk);
		#1;
		// an adder op queued behind the blocked head must not pass it
		if (followed) begin
			decode_info = follow;
			@(posedge clk);
			#1;
		end
		decode_push = 1'b0;
		if (stall_v[0]) begin
			repeat (3) @(negedge clk);
			check_level(name, 1'b0, seen_push.size() != 0);
			@(posedge clk);
			#1;
			issue_full = '0;
			su_empty = 1'b1;
			lu_busy = 1'b0;
			repeat (ncom_v) do_commit(name);
			wait_dispatch(name, unit, exp, entry);
			if (followed)
				wait_dispatch(name, dispatch_pkg::UNIT_ADDER, follow_exp, follow_entry);
		end else begin
			wait_dispatch(name, unit, exp, entry);
			repeat (ncom_v) do_commit(name);
		end
		repeat ($unsigned($random(seed)) % 3) @(posedge clk);
	endtask

	initial begin
		seed = 32'hde2f;
		clk = 1'b0;
		arst_n = 1'b0;
		decode_push = 1'b0;
		decode_info = '0;
		issue_full = '0;
		su_empty = 1'b1;
		lu_busy = 1'b0;
		commit = 1'b0;
		repeat (5) @(posedge clk);
		#1 arst_n = 1'b1;
		@(negedge clk);
		check_level("reset_push", 1'b0, |issue_push);
		check_level("reset_commit", 1'b0, commit_valid);
		check_level("reset_full", 1'b0, decode_full);
		fd = $fopen("verification/dispatch_cases.txt", "r");
		if (fd == 0)
			stop_run("could not open the cases file");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 1 && line[0] != "#") begin
				code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
					unit_v, op_v, pc_v, imm_v, rd0_v, rs1_v, rs2_v, rdv_v,
					full_v, su_v, lu_v, ncom_v, stall_v, ers1_v, ers2_v, erd0_v);
				if (code == 17)
					run_case();
				else
					stop_run($sformatf("a line of the cases file is malformed: %s", line));
			end
		end
		$fclose(fd);
		// retire whatever is left, still in dispatch order
		while (rob_model.size() > 0)
			do_commit("drain");
		@(negedge clk);
		check_level("drain_empty", 1'b0, commit_valid);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/dispatch_cases.txt */
# name unit op pc imm rd0 rs1 rs2 rd0_valid issue_full su_empty lu_busy commits stall
# then expected rs1_slot rs2_slot rd0_slot, all fields hex
route_adder   0 1 1000 5   1 0 0 1 00 1 0 1 0 0 0 0
route_logcmp  1 2 1004 7   2 1 0 1 00 1 0 1 0 0 0 0
route_shift   2 3 1008 3   3 2 1 1 00 1 0 1 0 0 0 0
route_jal     3 0 100c 10  1 0 0 1 00 1 0 1 0 0 0 0
route_bru     4 1 1010 20  0 1 2 0 00 1 0 1 0 0 0 0
route_lu      5 0 1014 8   4 2 0 1 00 1 0 1 0 0 0 0
route_su      6 2 1018 8   0 4 3 0 00 1 0 1 0 0 0 0
route_csr     7 1 101c 300 6 0 0 1 00 1 0 1 0 0 0 0
route_fence   8 0 1020 33  0 0 0 0 00 1 0 1 0 0 0 0
x5_write_a    0 0 2000 1   5 0 0 1 00 1 0 0 0 0 0 0
x5_write_b    0 0 2004 2   5 5 0 1 00 1 0 0 0 0 0 1
x5_write_c    0 0 2008 3   5 5 0 1 00 1 0 0 0 1 0 2
x5_read       1 0 200c 0   0 5 0 0 00 1 0 0 0 2 0 0
x5_write_d    0 0 2010 4   5 5 0 1 00 1 0 0 0 2 0 3
x5_run_out    0 0 2014 5   5 5 0 1 00 1 0 1 1 3 0 0
unit_full     2 1 2018 1   7 5 0 1 04 1 0 1 1 0 0 0
fence_store   8 0 201c 13  0 0 0 0 00 0 0 1 1 0 0 0
fence_load    8 0 2020 23  0 0 0 0 00 1 1 1 1 0 0 0
fence_i_lu    8 1 2024 0   0 0 0 0 00 1 1 1 1 0 0 0
fence_i_su    8 1 2028 0   0 0 0 0 00 0 0 1 1 0 0 0
fence_no_hold 8 0 202c 13  0 0 0 0 00 1 1 1 0 0 0 0

/* dispatch_top.f */
hw/dispatch_pkg.sv
hw/rename_if.sv
hw/sync_fifo.sv
hw/rename.sv
hw/dispatch.sv
hw/dispatch_top.sv
verification/dispatch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dispatch_top.f --top-module dispatch_tb -o dispatch_sim

./obj_dir/dispatch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0
